//--- design/turf_settings.svh
`ifndef TURF_SETTINGS_SVH
`define TURF_SETTINGS_SVH

// Register bus widths
`define TURF_ADDR_BITS 16
`define TURF_DATA_BITS 32

// Address bits 13:12 pick the register block and 3 is unmapped
`define TURF_SPACE_IDCTL  2'd0
`define TURF_SPACE_BRIDGE 2'd1
`define TURF_SPACE_GPIO   2'd2

// ASCII "TURF" identity word
`define TURF_IDENT 32'h54555246
// Date field in the upper half and version 0.4.14 below
`define TURF_DATEVERSION 32'h2C67_040E

`define TURF_NUM_LINKS 4

// Fractional baud increments
`define TURF_HSK_ADD  82
`define TURF_HSK_BITS 10
`define TURF_GPS_ADD  25
`define TURF_GPS_BITS 12

// All pins start out tristated
`define TURF_GPIO_T_RESET 16'hFFFF

`endif

//--- design/turf_pkg.sv
`include "turf_settings.svh"

package turf_pkg;

    //////////////////////////////
    // Register bus types
    //////////////////////////////

    typedef logic [`TURF_ADDR_BITS-1:0] reg_addr_t;
    typedef logic [`TURF_DATA_BITS-1:0] reg_data_t;

    // Only the two codes this slave ever returns
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

    //////////////////////////////
    // Crate bridge types
    //////////////////////////////

    // 0 is no bridge, 1 is Aurora
    typedef logic [1:0] bridge_type_t;
    typedef bridge_type_t [`TURF_NUM_LINKS-1:0] bridge_sel_t;
    typedef logic [4*`TURF_NUM_LINKS-1:0] bridge_valid_t;
    typedef logic [`TURF_NUM_LINKS-1:0] link_mask_t;

    // EMIO GPIO word
    typedef logic [15:0] gpio_word_t;

endpackage

//--- design/reg_bus_if.sv
// Single-outstanding register bus
// req pulses for one cycle, ack follows one cycle later
interface reg_bus_if;

    logic                req;
    logic                we;
    turf_pkg::reg_addr_t addr;
    turf_pkg::reg_data_t wdata;
    logic                ack;
    logic                err;
    turf_pkg::reg_data_t rdata;

    modport master (
        output req, we, addr, wdata,
        input  ack, err, rdata
    );

    modport slave (
        input  req, we, addr, wdata,
        output ack, err, rdata
    );

endinterface

//--- design/axil_reg_slave.sv
module axil_reg_slave (
    input  logic                ps_clk,
    input  logic                rst_i,
    input  logic                s_awvalid_i,
    output logic                s_awready_o,
    input  turf_pkg::reg_addr_t s_awaddr_i,
    input  logic                s_wvalid_i,
    output logic                s_wready_o,
    input  turf_pkg::reg_data_t s_wdata_i,
    output logic                s_bvalid_o,
    input  logic                s_bready_i,
    output turf_pkg::axi_resp_t s_bresp_o,
    input  logic                s_arvalid_i,
    output logic                s_arready_o,
    input  turf_pkg::reg_addr_t s_araddr_i,
    output logic                s_rvalid_o,
    input  logic                s_rready_i,
    output turf_pkg::reg_data_t s_rdata_o,
    output turf_pkg::axi_resp_t s_rresp_o,
    reg_bus_if.master           bus_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REQ,
        ST_WAIT,
        ST_RESP
    } state_t;

    state_t              state;
    logic                req_q;
    logic                we_q;
    turf_pkg::reg_addr_t addr_q;
    turf_pkg::reg_data_t wdata_q;
    turf_pkg::reg_data_t rdata_q;
    turf_pkg::axi_resp_t resp_q;

    //////////////////////////////
    // Transaction FSM
    //////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            state       <= ST_IDLE;
            s_awready_o <= 1'b0;
            s_wready_o  <= 1'b0;
            s_arready_o <= 1'b0;
            req_q       <= 1'b0;
            s_bvalid_o  <= 1'b0;
            s_rvalid_o  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Write wins when both directions are pending
                    if (s_awvalid_i && s_wvalid_i) begin
                        s_awready_o <= 1'b1;
                        s_wready_o  <= 1'b1;
                        state       <= ST_REQ;
                    end else if (s_arvalid_i) begin
                        s_arready_o <= 1'b1;
                        state       <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    s_awready_o <= 1'b0;
                    s_wready_o  <= 1'b0;
                    s_arready_o <= 1'b0;
                    req_q       <= 1'b1;
                    state       <= ST_WAIT;
                end
                ST_WAIT: begin
                    req_q <= 1'b0;
                    if (bus_o.ack) begin
                        s_bvalid_o <= we_q;
                        s_rvalid_o <= !we_q;
                        state      <= ST_RESP;
                    end
                end
                default: begin
                    // Held here under back-pressure
                    if ((s_bvalid_o && s_bready_i) || (s_rvalid_o && s_rready_i)) begin
                        s_bvalid_o <= 1'b0;
                        s_rvalid_o <= 1'b0;
                        state      <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Captured address, data and response
    always_ff @(posedge ps_clk) begin
        if (state == ST_IDLE) begin
            if (s_awvalid_i && s_wvalid_i) begin
                we_q    <= 1'b1;
                addr_q  <= s_awaddr_i;
                wdata_q <= s_wdata_i;
            end else if (s_arvalid_i) begin
                we_q   <= 1'b0;
                addr_q <= s_araddr_i;
            end
        end
        if (state == ST_WAIT && bus_o.ack) begin
            rdata_q <= bus_o.rdata;
            resp_q  <= bus_o.err ? turf_pkg::SLVERR : turf_pkg::OKAY;
        end
    end

    assign bus_o.req   = req_q;
    assign bus_o.we    = we_q;
    assign bus_o.addr  = addr_q;
    assign bus_o.wdata = wdata_q;

    assign s_bresp_o = resp_q;
    assign s_rresp_o = resp_q;
    assign s_rdata_o = rdata_q;

    a_bvalid_hold: assert property (@(posedge ps_clk) disable iff (rst_i)
        s_bvalid_o && !s_bready_i |=> s_bvalid_o);

    a_rvalid_hold: assert property (@(posedge ps_clk) disable iff (rst_i)
        s_rvalid_o && !s_rready_i |=> s_rvalid_o);

endmodule

//--- design/reg_space_decode.sv
`include "turf_settings.svh"

module reg_space_decode (
    input  logic      ps_clk,
    input  logic      rst_i,
    reg_bus_if.slave  bus_i,
    reg_bus_if.master idctl_o,
    reg_bus_if.master bridge_o,
    reg_bus_if.master gpio_o
);

    logic [1:0] space;
    logic       unmapped_ack;

    assign space = bus_i.addr[13:12];

    // Request goes out in the same cycle
    assign idctl_o.req  = bus_i.req && (space == `TURF_SPACE_IDCTL);
    assign bridge_o.req = bus_i.req && (space == `TURF_SPACE_BRIDGE);
    assign gpio_o.req   = bus_i.req && (space == `TURF_SPACE_GPIO);

    assign idctl_o.we     = bus_i.we;
    assign idctl_o.addr   = bus_i.addr;
    assign idctl_o.wdata  = bus_i.wdata;
    assign bridge_o.we    = bus_i.we;
    assign bridge_o.addr  = bus_i.addr;
    assign bridge_o.wdata = bus_i.wdata;
    assign gpio_o.we      = bus_i.we;
    assign gpio_o.addr    = bus_i.addr;
    assign gpio_o.wdata   = bus_i.wdata;

    // Space 3 answers itself with an error
    always_ff @(posedge ps_clk) begin
        if (rst_i) unmapped_ack <= 1'b0;
        else       unmapped_ack <= bus_i.req && (space == 2'd3);
    end

    assign bus_i.ack = idctl_o.ack | bridge_o.ack | gpio_o.ack | unmapped_ack;
    assign bus_i.err = unmapped_ack | idctl_o.err | bridge_o.err | gpio_o.err;

    always_comb begin
        bus_i.rdata = '0;
        if (idctl_o.ack)       bus_i.rdata = idctl_o.rdata;
        else if (bridge_o.ack) bus_i.rdata = bridge_o.rdata;
        else if (gpio_o.ack)   bus_i.rdata = gpio_o.rdata;
    end

    a_one_ack: assert property (@(posedge ps_clk) disable iff (rst_i)
        $onehot0({idctl_o.ack, bridge_o.ack, gpio_o.ack, unmapped_ack}));

endmodule

//--- design/id_ctrl_regs.sv
`include "turf_settings.svh"

module id_ctrl_regs (
    input  logic                  ps_clk,
    input  logic                  rst_i,
    reg_bus_if.slave              bus_i,
    output turf_pkg::bridge_sel_t bridge_sel_o
);

    turf_pkg::reg_data_t scratch_q;

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            bus_i.ack    <= 1'b0;
            bridge_sel_o <= '0;
            scratch_q    <= '0;
        end else begin
            bus_i.ack <= bus_i.req;
            // Identity and version words ignore writes
            if (bus_i.req && bus_i.we) begin
                case (bus_i.addr[11:0])
                    12'h008: bridge_sel_o <= turf_pkg::bridge_sel_t'(bus_i.wdata[7:0]);
                    12'h00C: scratch_q    <= bus_i.wdata;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (bus_i.req) begin
            case (bus_i.addr[11:0])
                12'h000: bus_i.rdata <= `TURF_IDENT;
                12'h004: bus_i.rdata <= `TURF_DATEVERSION;
                12'h008: bus_i.rdata <= {24'd0, bridge_sel_o};
                12'h00C: bus_i.rdata <= scratch_q;
                default: bus_i.rdata <= '0;
            endcase
        end
    end

    assign bus_i.err = 1'b0;

    // Also catches a master issuing back-to-back requests
    a_ack_next: assert property (@(posedge ps_clk) disable iff (rst_i)
        bus_i.req |=> bus_i.ack && !bus_i.req);

endmodule

//--- design/bridge_status_regs.sv
`include "turf_settings.svh"

module bridge_status_regs (
    input  logic                  ps_clk,
    input  logic                  rst_i,
    reg_bus_if.slave              bus_i,
    input  turf_pkg::bridge_sel_t bridge_sel_i,
    input  turf_pkg::link_mask_t  aurora_up_i,
    input  turf_pkg::link_mask_t  bridge_timeout_i,
    input  turf_pkg::link_mask_t  bridge_invalid_i,
    output turf_pkg::link_mask_t  bridge_ok_o
);

    turf_pkg::bridge_valid_t valid_map;
    turf_pkg::link_mask_t    timeout_q;
    turf_pkg::link_mask_t    invalid_q;
    turf_pkg::link_mask_t    clr_timeout;
    turf_pkg::link_mask_t    clr_invalid;
    logic                    flag_wr;

    //////////////////////////////
    // Valid map and bridge ok
    //////////////////////////////

    // No bridge is always valid and Aurora only when its link is up
    // Types 2 and 3 are not implemented
    always_comb begin
        for (int n = 0; n < `TURF_NUM_LINKS; n++) begin
            valid_map[4*n +: 4] = {2'b00, aurora_up_i[n], 1'b1};
            bridge_ok_o[n]      = valid_map[4*n + bridge_sel_i[n]];
        end
    end

    // Write 1 to clear
    assign flag_wr     = bus_i.req && bus_i.we && (bus_i.addr[11:0] == 12'h004);
    assign clr_timeout = flag_wr ? bus_i.wdata[3:0] : '0;
    assign clr_invalid = flag_wr ? bus_i.wdata[7:4] : '0;

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            bus_i.ack <= 1'b0;
            timeout_q <= '0;
            invalid_q <= '0;
        end else begin
            bus_i.ack <= bus_i.req;
            // A live input keeps its flag set
            timeout_q <= (timeout_q & ~clr_timeout) | bridge_timeout_i;
            invalid_q <= (invalid_q & ~clr_invalid) | bridge_invalid_i;
        end
    end

    always_ff @(posedge ps_clk) begin
        if (bus_i.req) begin
            case (bus_i.addr[11:0])
                12'h000: bus_i.rdata <= {16'd0, valid_map};
                12'h004: bus_i.rdata <= {24'd0, invalid_q, timeout_q};
                default: bus_i.rdata <= '0;
            endcase
        end
    end

    assign bus_i.err = 1'b0;

endmodule

//--- design/emio_gpio_regs.sv
`include "turf_settings.svh"

module emio_gpio_regs (
    input  logic       ps_clk,
    input  logic       rst_i,
    reg_bus_if.slave   bus_i,
    output logic [3:0] tresetb_o,
    output logic [3:0] tresetb_oe_o,
    input  logic [3:0] tresetb_i,
    output logic [1:0] gps_extint_o,
    input  logic [1:0] gps_timepulse_i,
    input  logic       hsk_irq_i,
    input  logic       hsk_complete_i,
    input  logic       uart_irq_b_i
);

    turf_pkg::gpio_word_t out_q;
    turf_pkg::gpio_word_t tri_q;
    turf_pkg::gpio_word_t in_raw;
    turf_pkg::gpio_word_t in_meta;
    turf_pkg::gpio_word_t in_sync;

    // TURFIO resets on top, then GPS timepulse, HSK and UART status at the bottom
    assign in_raw = {tresetb_i, gps_timepulse_i, 7'd0, hsk_complete_i, hsk_irq_i, uart_irq_b_i};

    // Two-flop synchronizer
    always_ff @(posedge ps_clk) begin
        in_meta <= in_raw;
        in_sync <= in_meta;
    end

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            bus_i.ack <= 1'b0;
            out_q     <= '0;
            tri_q     <= `TURF_GPIO_T_RESET;
        end else begin
            bus_i.ack <= bus_i.req;
            if (bus_i.req && bus_i.we) begin
                case (bus_i.addr[11:0])
                    12'h000: out_q <= bus_i.wdata[15:0];
                    12'h004: tri_q <= bus_i.wdata[15:0];
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (bus_i.req) begin
            case (bus_i.addr[11:0])
                12'h000: bus_i.rdata <= {16'd0, out_q};
                12'h004: bus_i.rdata <= {16'd0, tri_q};
                12'h008: bus_i.rdata <= {16'd0, in_sync};
                default: bus_i.rdata <= '0;
            endcase
        end
    end

    assign bus_i.err = 1'b0;

    //////////////////////////////
    // Pin outputs
    //////////////////////////////

    assign tresetb_o    = out_q[15:12];
    assign tresetb_oe_o = ~tri_q[15:12];
    // EXTINT is only driven when enabled
    assign gps_extint_o = out_q[9:8] & ~tri_q[9:8];

endmodule

//--- design/baud_tick_gen.sv
module baud_tick_gen #(
    parameter int ACC_BITS  = 10,
    parameter int INCREMENT = 82
) (
    input  logic ps_clk,
    input  logic rst_i,
    output logic tick_o
);

    logic [ACC_BITS-1:0] acc;
    logic [ACC_BITS:0]   sum;

    // Carry out of the accumulator is the tick
    assign sum = {1'b0, acc} + (ACC_BITS + 1)'(INCREMENT);

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            acc    <= '0;
            tick_o <= 1'b0;
        end else begin
            acc    <= sum[ACC_BITS-1:0];
            tick_o <= sum[ACC_BITS];
        end
    end

endmodule

//--- design/turf_ctrl_top.sv
`include "turf_settings.svh"

module turf_ctrl_top (
    input  logic                 ps_clk,
    input  logic                 rst_i,
    input  logic                 s_awvalid_i,
    output logic                 s_awready_o,
    input  turf_pkg::reg_addr_t  s_awaddr_i,
    input  logic                 s_wvalid_i,
    output logic                 s_wready_o,
    input  turf_pkg::reg_data_t  s_wdata_i,
    output logic                 s_bvalid_o,
    input  logic                 s_bready_i,
    output turf_pkg::axi_resp_t  s_bresp_o,
    input  logic                 s_arvalid_i,
    output logic                 s_arready_o,
    input  turf_pkg::reg_addr_t  s_araddr_i,
    output logic                 s_rvalid_o,
    input  logic                 s_rready_i,
    output turf_pkg::reg_data_t  s_rdata_o,
    output turf_pkg::axi_resp_t  s_rresp_o,
    input  turf_pkg::link_mask_t aurora_up_i,
    input  turf_pkg::link_mask_t bridge_timeout_i,
    input  turf_pkg::link_mask_t bridge_invalid_i,
    output turf_pkg::link_mask_t bridge_ok_o,
    output logic [3:0]           tresetb_o,
    output logic [3:0]           tresetb_oe_o,
    input  logic [3:0]           tresetb_i,
    output logic [1:0]           gps_extint_o,
    input  logic [1:0]           gps_timepulse_i,
    input  logic                 hsk_irq_i,
    input  logic                 hsk_complete_i,
    input  logic                 uart_irq_b_i,
    output logic                 hsk_tick_o,
    output logic                 gps_tick_o
);

    reg_bus_if ps_bus ();
    reg_bus_if idctl_bus ();
    reg_bus_if bridge_bus ();
    reg_bus_if gpio_bus ();

    turf_pkg::bridge_sel_t bridge_sel;

    //////////////////////////////
    // Register path
    //////////////////////////////

    axil_reg_slave u_axil (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o), .s_awaddr_i(s_awaddr_i),
        .s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o), .s_wdata_i(s_wdata_i),
        .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i), .s_bresp_o(s_bresp_o),
        .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o), .s_araddr_i(s_araddr_i),
        .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
        .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o),
        .bus_o(ps_bus.master)
    );

    reg_space_decode u_decode (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .bus_i(ps_bus.slave),
        .idctl_o(idctl_bus.master),
        .bridge_o(bridge_bus.master),
        .gpio_o(gpio_bus.master)
    );

    id_ctrl_regs u_idctl (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .bus_i(idctl_bus.slave),
        .bridge_sel_o(bridge_sel)
    );

    bridge_status_regs u_bridge (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .bus_i(bridge_bus.slave),
        .bridge_sel_i(bridge_sel),
        .aurora_up_i(aurora_up_i),
        .bridge_timeout_i(bridge_timeout_i),
        .bridge_invalid_i(bridge_invalid_i),
        .bridge_ok_o(bridge_ok_o)
    );

    emio_gpio_regs u_gpio (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .bus_i(gpio_bus.slave),
        .tresetb_o(tresetb_o), .tresetb_oe_o(tresetb_oe_o), .tresetb_i(tresetb_i),
        .gps_extint_o(gps_extint_o), .gps_timepulse_i(gps_timepulse_i),
        .hsk_irq_i(hsk_irq_i), .hsk_complete_i(hsk_complete_i),
        .uart_irq_b_i(uart_irq_b_i)
    );

    // 16x baud ticks for the HSK and GPS serial ports
    baud_tick_gen #(.ACC_BITS(`TURF_HSK_BITS), .INCREMENT(`TURF_HSK_ADD)) u_hsk_baud (
        .ps_clk(ps_clk), .rst_i(rst_i), .tick_o(hsk_tick_o)
    );

    baud_tick_gen #(.ACC_BITS(`TURF_GPS_BITS), .INCREMENT(`TURF_GPS_ADD)) u_gps_baud (
        .ps_clk(ps_clk), .rst_i(rst_i), .tick_o(gps_tick_o)
    );

endmodule

//--- verif/turf_ctrl_tb.sv
`include "turf_settings.svh"

module turf_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 50;
    localparam int tick_window = 4096;
    localparam turf_pkg::reg_addr_t idctl_base  = {2'b00, `TURF_SPACE_IDCTL, 12'h000};
    localparam turf_pkg::reg_addr_t bridge_base = {2'b00, `TURF_SPACE_BRIDGE, 12'h000};
    localparam turf_pkg::reg_addr_t gpio_base   = {2'b00, `TURF_SPACE_GPIO, 12'h000};
    localparam turf_pkg::reg_addr_t unmapped_base = 16'h3000;
    localparam turf_pkg::gpio_word_t gpio_out_val = 16'hA300;
    localparam turf_pkg::gpio_word_t gpio_tri_val = 16'h3E00;

    typedef enum {OP_WRITE, OP_READ} op_t;

    typedef struct {
        string               name;
        op_t                 op;
        turf_pkg::reg_addr_t addr;
        turf_pkg::reg_data_t wdata;
        turf_pkg::reg_data_t exp_data;
        turf_pkg::axi_resp_t exp_resp;
    } table_entry_t;

    logic                 ps_clk;
    logic                 rst_i;
    logic                 s_awvalid_i;
    logic                 s_awready_o;
    turf_pkg::reg_addr_t  s_awaddr_i;
    logic                 s_wvalid_i;
    logic                 s_wready_o;
    turf_pkg::reg_data_t  s_wdata_i;
    logic                 s_bvalid_o;
    logic                 s_bready_i;
    turf_pkg::axi_resp_t  s_bresp_o;
    logic                 s_arvalid_i;
    logic                 s_arready_o;
    turf_pkg::reg_addr_t  s_araddr_i;
    logic                 s_rvalid_o;
    logic                 s_rready_i;
    turf_pkg::reg_data_t  s_rdata_o;
    turf_pkg::axi_resp_t  s_rresp_o;
    turf_pkg::link_mask_t aurora_up_i;
    turf_pkg::link_mask_t bridge_timeout_i;
    turf_pkg::link_mask_t bridge_invalid_i;
    turf_pkg::link_mask_t bridge_ok_o;
    logic [3:0]           tresetb_o;
    logic [3:0]           tresetb_oe_o;
    logic [3:0]           tresetb_i;
    logic [1:0]           gps_extint_o;
    logic [1:0]           gps_timepulse_i;
    logic                 hsk_irq_i;
    logic                 hsk_complete_i;
    logic                 uart_irq_b_i;
    logic                 hsk_tick_o;
    logic                 gps_tick_o;

    table_entry_t table_q[$];
    int           seed;

    turf_ctrl_top dut0 (
        .ps_clk(ps_clk), .rst_i(rst_i),
        .s_awvalid_i(s_awvalid_i), .s_awready_o(s_awready_o), .s_awaddr_i(s_awaddr_i),
        .s_wvalid_i(s_wvalid_i), .s_wready_o(s_wready_o), .s_wdata_i(s_wdata_i),
        .s_bvalid_o(s_bvalid_o), .s_bready_i(s_bready_i), .s_bresp_o(s_bresp_o),
        .s_arvalid_i(s_arvalid_i), .s_arready_o(s_arready_o), .s_araddr_i(s_araddr_i),
        .s_rvalid_o(s_rvalid_o), .s_rready_i(s_rready_i),
        .s_rdata_o(s_rdata_o), .s_rresp_o(s_rresp_o),
        .aurora_up_i(aurora_up_i), .bridge_timeout_i(bridge_timeout_i),
        .bridge_invalid_i(bridge_invalid_i), .bridge_ok_o(bridge_ok_o),
        .tresetb_o(tresetb_o), .tresetb_oe_o(tresetb_oe_o), .tresetb_i(tresetb_i),
        .gps_extint_o(gps_extint_o), .gps_timepulse_i(gps_timepulse_i),
        .hsk_irq_i(hsk_irq_i), .hsk_complete_i(hsk_complete_i),
        .uart_irq_b_i(uart_irq_b_i),
        .hsk_tick_o(hsk_tick_o), .gps_tick_o(gps_tick_o)
    );

    initial begin
        ps_clk = 1'b0;
        forever #50 ps_clk = ~ps_clk;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic compare_data(input string name, input turf_pkg::reg_data_t exp_val,
                                input turf_pkg::reg_data_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s expected %h actual %h", name, exp_val, act_val);
            $display("Testbench failed");
            $fatal(1, "Data check did not match");
        end
    endtask

    task automatic compare_resp(input string name, input turf_pkg::axi_resp_t exp_val,
                                input turf_pkg::axi_resp_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s expected %b actual %b", name, exp_val, act_val);
            $display("Testbench failed");
            $fatal(1, "Response check did not match");
        end
    endtask

    task automatic compare_mask(input string name, input turf_pkg::link_mask_t exp_val,
                                input turf_pkg::link_mask_t act_val);
        if (act_val !== exp_val) begin
            $display("Mismatch %s expected %b actual %b", name, exp_val, act_val);
            $display("Testbench failed");
            $fatal(1, "Mask check did not match");
        end
    endtask

    task automatic compare_count(input string name, input int exp_val, input int act_val);
        if (act_val != exp_val) begin
            $display("Mismatch %s expected %0d actual %0d", name, exp_val, act_val);
            $display("Testbench failed");
            $fatal(1, "Count check did not match");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Testbench failed");
        $fatal(1, "Timed out waiting for %s", what);
    endtask

    //////////////////////////////
    // AXI4-Lite driver
    //////////////////////////////

    task automatic axil_write(input turf_pkg::reg_addr_t addr, input turf_pkg::reg_data_t data,
                              output turf_pkg::axi_resp_t resp);
        int cycles;
        @(posedge ps_clk);
        s_awvalid_i <= 1'b1;
        s_awaddr_i  <= addr;
        s_wvalid_i  <= 1'b1;
        s_wdata_i   <= data;
        cycles = 0;
        @(negedge ps_clk);
        while (!(s_awready_o && s_wready_o)) begin
            if (cycles == timeout_cycles) stop_on_timeout("awready and wready");
            cycles++;
            @(negedge ps_clk);
        end
        @(posedge ps_clk);
        s_awvalid_i <= 1'b0;
        s_wvalid_i  <= 1'b0;
        cycles = 0;
        @(negedge ps_clk);
        while (!s_bvalid_o) begin
            if (cycles == timeout_cycles) stop_on_timeout("bvalid");
            cycles++;
            @(negedge ps_clk);
        end
        resp = s_bresp_o;
        @(posedge ps_clk);
        s_bready_i <= 1'b1;
        @(posedge ps_clk);
        s_bready_i <= 1'b0;
    endtask

    task automatic axil_read(input turf_pkg::reg_addr_t addr, output turf_pkg::reg_data_t data,
                             output turf_pkg::axi_resp_t resp);
        int cycles;
        @(posedge ps_clk);
        s_arvalid_i <= 1'b1;
        s_araddr_i  <= addr;
        cycles = 0;
        @(negedge ps_clk);
        while (!s_arready_o) begin
            if (cycles == timeout_cycles) stop_on_timeout("arready");
            cycles++;
            @(negedge ps_clk);
        end
        @(posedge ps_clk);
        s_arvalid_i <= 1'b0;
        cycles = 0;
        @(negedge ps_clk);
        while (!s_rvalid_o) begin
            if (cycles == timeout_cycles) stop_on_timeout("rvalid");
            cycles++;
            @(negedge ps_clk);
        end
        data = s_rdata_o;
        resp = s_rresp_o;
        @(posedge ps_clk);
        s_rready_i <= 1'b1;
        @(posedge ps_clk);
        s_rready_i <= 1'b0;
    endtask

    function automatic void add_entry(input string name, input op_t op,
                                      input turf_pkg::reg_addr_t addr,
                                      input turf_pkg::reg_data_t wdata,
                                      input turf_pkg::reg_data_t exp_data,
                                      input turf_pkg::axi_resp_t exp_resp);
        table_entry_t e;
        e.name     = name;
        e.op       = op;
        e.addr     = addr;
        e.wdata    = wdata;
        e.exp_data = exp_data;
        e.exp_resp = exp_resp;
        table_q.push_back(e);
    endfunction

    // Bit 0 of each link nibble is no bridge and bit 1 is Aurora up
    function automatic turf_pkg::reg_data_t valid_map_of(input turf_pkg::link_mask_t up);
        turf_pkg::reg_data_t map;
        map = '0;
        for (int n = 0; n < `TURF_NUM_LINKS; n++) begin
            map[4*n]     = 1'b1;
            map[4*n + 1] = up[n];
        end
        return map;
    endfunction

    initial begin
        turf_pkg::reg_data_t  rdata;
        turf_pkg::axi_resp_t  resp;
        turf_pkg::bridge_sel_t sel;
        turf_pkg::link_mask_t up;
        turf_pkg::link_mask_t exp_ok;
        turf_pkg::reg_data_t  flags;
        turf_pkg::reg_data_t  exp_in;
        logic [31:0]          rnd;
        int                   hsk_count;
        int                   gps_count;

        seed = 32'h1dae3e2d;
        rst_i            <= 1'b1;
        s_awvalid_i      <= 1'b0;
        s_awaddr_i       <= '0;
        s_wvalid_i       <= 1'b0;
        s_wdata_i        <= '0;
        s_bready_i       <= 1'b0;
        s_arvalid_i      <= 1'b0;
        s_araddr_i       <= '0;
        s_rready_i       <= 1'b0;
        aurora_up_i      <= '0;
        bridge_timeout_i <= '0;
        bridge_invalid_i <= '0;
        tresetb_i        <= '0;
        gps_timepulse_i  <= '0;
        hsk_irq_i        <= 1'b0;
        hsk_complete_i   <= 1'b0;
        uart_irq_b_i     <= 1'b1;
        repeat (3) @(posedge ps_clk);
        rst_i <= 1'b0;
        @(posedge ps_clk);

        // Tick count over a whole accumulator period while the bus is idle
        hsk_count = 0;
        gps_count = 0;
        repeat (tick_window) begin
            @(negedge ps_clk);
            if (hsk_tick_o) hsk_count++;
            if (gps_tick_o) gps_count++;
        end
        compare_count("hsk_ticks", (tick_window >> `TURF_HSK_BITS) * `TURF_HSK_ADD, hsk_count);
        compare_count("gps_ticks", (tick_window >> `TURF_GPS_BITS) * `TURF_GPS_ADD, gps_count);
        compare_mask("tresetb_oe_reset", '0, tresetb_oe_o);
        compare_mask("gps_extint_reset", '0, {2'b00, gps_extint_o});

        //////////////////////////////
        // Register table
        //////////////////////////////

        add_entry("ident_rd", OP_READ, idctl_base, '0, `TURF_IDENT, turf_pkg::OKAY);
        add_entry("dv_rd", OP_READ, idctl_base + 4, '0, `TURF_DATEVERSION, turf_pkg::OKAY);
        add_entry("scratch_wr", OP_WRITE, idctl_base + 12, 32'hA5C3_0F1E, '0, turf_pkg::OKAY);
        add_entry("scratch_rd", OP_READ, idctl_base + 12, '0, 32'hA5C3_0F1E, turf_pkg::OKAY);
        add_entry("sel_wr", OP_WRITE, idctl_base + 8, 32'hFFFF_FF96, '0, turf_pkg::OKAY);
        add_entry("sel_rd", OP_READ, idctl_base + 8, '0, 32'h0000_0096, turf_pkg::OKAY);
        add_entry("ident_wr", OP_WRITE, idctl_base, 32'hDEAD_BEEF, '0, turf_pkg::OKAY);
        add_entry("ident_rd_again", OP_READ, idctl_base, '0, `TURF_IDENT, turf_pkg::OKAY);
        add_entry("undef_rd", OP_READ, idctl_base + 16, '0, '0, turf_pkg::OKAY);
        add_entry("unmapped_wr", OP_WRITE, unmapped_base, 32'h1234_5678, '0, turf_pkg::SLVERR);
        add_entry("unmapped_rd", OP_READ, unmapped_base + 4, '0, '0, turf_pkg::SLVERR);
        add_entry("gpio_out_wr", OP_WRITE, gpio_base, {16'd0, gpio_out_val}, '0, turf_pkg::OKAY);
        add_entry("gpio_out_rd", OP_READ, gpio_base, '0, {16'd0, gpio_out_val}, turf_pkg::OKAY);
        add_entry("gpio_tri_wr", OP_WRITE, gpio_base + 4, {16'd0, gpio_tri_val}, '0,
                  turf_pkg::OKAY);
        add_entry("gpio_tri_rd", OP_READ, gpio_base + 4, '0, {16'd0, gpio_tri_val},
                  turf_pkg::OKAY);

        foreach (table_q[i]) begin
            if (table_q[i].op == OP_WRITE) begin
                axil_write(table_q[i].addr, table_q[i].wdata, resp);
            end else begin
                axil_read(table_q[i].addr, rdata, resp);
                compare_data(table_q[i].name, table_q[i].exp_data, rdata);
            end
            compare_resp(table_q[i].name, table_q[i].exp_resp, resp);
        end

        // GPIO pins from the output and tristate words
        @(negedge ps_clk);
        compare_mask("tresetb_pins", gpio_out_val[15:12], tresetb_o);
        compare_mask("tresetb_oe", ~gpio_tri_val[15:12], tresetb_oe_o);
        compare_mask("gps_extint", {2'b00, gpio_out_val[9:8] & ~gpio_tri_val[9:8]},
                     {2'b00, gps_extint_o});

        //////////////////////////////
        // Bridge valid map and ok
        //////////////////////////////

        for (int round = 0; round < 4; round++) begin
            rnd = $random(seed);
            up = rnd[3:0];
            @(posedge ps_clk);
            aurora_up_i <= up;
            axil_read(bridge_base, rdata, resp);
            compare_data($sformatf("valid_map_%0d", round), valid_map_of(up), rdata);
            compare_resp($sformatf("valid_map_%0d", round), turf_pkg::OKAY, resp);
            // All type 0, then all type 1, then a random mix of the two
            for (int n = 0; n < `TURF_NUM_LINKS; n++) begin
                if (round == 0) sel[n] = 2'd0;
                else if (round == 1) sel[n] = 2'd1;
                else sel[n] = {1'b0, rnd[8 + n]};
                exp_ok[n] = (sel[n] == 2'd0) ? 1'b1 : up[n];
            end
            axil_write(idctl_base + 8, {24'd0, sel}, resp);
            @(negedge ps_clk);
            compare_mask($sformatf("bridge_ok_%0d", round), exp_ok, bridge_ok_o);
        end

        // Sticky timeout and invalid flags
        rnd = $random(seed);
        @(posedge ps_clk);
        bridge_timeout_i <= rnd[3:0];
        bridge_invalid_i <= rnd[7:4];
        @(posedge ps_clk);
        bridge_timeout_i <= '0;
        bridge_invalid_i <= '0;
        flags = {24'd0, rnd[7:0]};
        axil_read(bridge_base + 4, rdata, resp);
        compare_data("flags_set", flags, rdata);
        axil_write(bridge_base + 4, {24'd0, rnd[15:8]}, resp);
        axil_read(bridge_base + 4, rdata, resp);
        compare_data("flags_part_clear", flags & ~{24'd0, rnd[15:8]}, rdata);
        axil_write(bridge_base + 4, 32'h0000_00FF, resp);
        axil_read(bridge_base + 4, rdata, resp);
        compare_data("flags_all_clear", '0, rdata);

        // Input word after the synchronizer settles
        rnd = $random(seed);
        @(posedge ps_clk);
        tresetb_i       <= rnd[3:0];
        gps_timepulse_i <= rnd[5:4];
        hsk_irq_i       <= rnd[6];
        hsk_complete_i  <= rnd[7];
        uart_irq_b_i    <= rnd[8];
        repeat (5) @(posedge ps_clk);
        exp_in = {16'd0, rnd[3:0], rnd[5:4], 7'd0, rnd[7], rnd[6], rnd[8]};
        axil_read(gpio_base + 8, rdata, resp);
        compare_data("gpio_inputs", exp_in, rdata);
        compare_resp("gpio_inputs", turf_pkg::OKAY, resp);

        $display("Testbench passed");
        $finish;
    end

endmodule

//--- all.f
+incdir+design
design/turf_pkg.sv
design/reg_bus_if.sv
design/axil_reg_slave.sv
design/reg_space_decode.sv
design/id_ctrl_regs.sv
design/bridge_status_regs.sv
design/emio_gpio_regs.sv
design/baud_tick_gen.sv
design/turf_ctrl_top.sv
verif/turf_ctrl_tb.sv

//--- Makefile
# Verilator build and run for the TURF control plane testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		-f all.f --top-module turf_ctrl_tb -o sim_tb

# Passes only when the simulation prints the pass message
run: compile
	@out=$$(./obj_dir/sim_tb); echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
